//--- obi_mon_pkg.sv
// OBI monitor shared definitions
// Widths, violation flag layouts, register map and status word
`default_nettype none

package obi_mon_pkg;

  // Default bus widths, passed down by the top level
  localparam int unsigned obi_addr_width_default = 32;
  localparam int unsigned obi_data_width_default = 32;

  // Register data word width
  localparam int unsigned cfg_width = 16;

  // ------------------------------
  // Violation flags
  // ------------------------------

  // Address phase flags, addr_unstable is bit 0
  typedef struct packed {
    logic be_addr_mismatch;
    logic be_gap;
    logic be_zero;
    logic req_dropped;
    logic wdata_unstable;
    logic ctrl_unstable;
    logic addr_unstable;
  } viol_flags_t;

  // Response phase flags, rvalid_orphan is the low bit
  typedef struct packed {
    logic outstanding_overflow;
    logic rvalid_orphan;
  } r_viol_flags_t;

  // Status and mask word, raw bits or decoded per phase
  typedef union packed {
    logic [cfg_width-1:0] raw;
    struct packed {
      logic [6:0]    pad;
      r_viol_flags_t r_flags;
      viol_flags_t   a_flags;
    } fields;
  } viol_status_u;

  // Register index
  typedef enum logic [1:0] {
    reg_ctrl       = 2'd0,
    reg_status     = 2'd1,
    reg_viol_count = 2'd2,
    reg_txn_count  = 2'd3
  } reg_addr_e;

endpackage

`default_nettype wire

//--- obi_if.sv
// OBI 1.1 link bundle
// Address and response phase signals of one manager/subordinate pair
`timescale 1ns/1ps
`default_nettype none

interface obi_if #(
  parameter int unsigned addr_width = 32,
  parameter int unsigned data_width = 32
);

  // Address phase
  logic                    req;
  logic                    gnt;
  logic [addr_width-1:0]   addr;
  logic                    we;
  logic [data_width/8-1:0] be;
  logic [data_width-1:0]   wdata;

  // Response phase
  logic                    rvalid;
  logic [data_width-1:0]   rdata;

  // Bus side, fills the bundle
  modport bus (
    output req, gnt, addr, we, be, wdata, rvalid, rdata
  );

  // Passive view for the checkers
  modport monitor (
    input req, gnt, addr, we, be, wdata, rvalid, rdata
  );

endinterface

`default_nettype wire

//--- obi_a_phase_checker.sv
// OBI address phase checker
// Flags stall stability, req drop and write byte enable errors
`timescale 1ns/1ps
`default_nettype none

module obi_a_phase_checker
  import obi_mon_pkg::*;
#(
  parameter int unsigned addr_width = 32,
  parameter int unsigned data_width = 32
) (
  input  wire          clk,
  input  wire          reset_n,
  obi_if.monitor       bus,
  input  viol_status_u enable,
  output viol_flags_t  a_viol
);

  localparam int unsigned be_width  = data_width / 8;
  localparam int unsigned lsb_width = (be_width > 1) ? $clog2(be_width) : 1;

  // ------------------------------
  // Previous cycle copy
  // ------------------------------

  logic                  prev_req;
  logic                  prev_gnt;
  logic [addr_width-1:0] prev_addr;
  logic                  prev_we;
  logic [be_width-1:0]   prev_be;
  logic [data_width-1:0] prev_wdata;

  // Handshake bits need a clean start
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      prev_req <= 1'b0;
      prev_gnt <= 1'b0;
    end else begin
      prev_req <= bus.req;
      prev_gnt <= bus.gnt;
    end
  end

  always_ff @(posedge clk) begin
    prev_addr  <= bus.addr;
    prev_we    <= bus.we;
    prev_be    <= bus.be;
    prev_wdata <= bus.wdata;
  end

  // Index of lowest set byte enable, zero when none
  function automatic logic [lsb_width-1:0] lowest_be(input logic [be_width-1:0] be);
    logic [lsb_width-1:0] idx;
    idx = '0;
    for (int i = be_width - 1; i >= 0; i--) begin
      if (be[i]) begin
        idx = lsb_width'(i);
      end
    end
    return idx;
  endfunction

  // ------------------------------
  // Detection
  // ------------------------------

  logic                stalled;
  logic                wr_phase;
  logic [be_width-1:0] be_low;
  viol_flags_t         det;

  always_comb begin
    // Previous cycle held req without grant
    stalled  = prev_req && !prev_gnt;
    wr_phase = bus.req && bus.we;
    // Isolate lowest set bit
    be_low   = bus.be & (~bus.be + 1'b1);

    det = '0;

    // Fields only matter while req is still up
    det.addr_unstable  = stalled && bus.req && (bus.addr != prev_addr);
    det.ctrl_unstable  = stalled && bus.req && ({bus.we, bus.be} != {prev_we, prev_be});
    // Write data is don't care on reads
    det.wdata_unstable = stalled && bus.req && prev_we && (bus.wdata != prev_wdata);
    det.req_dropped    = stalled && !bus.req;

    det.be_zero = wr_phase && (bus.be == '0);
    // Adding the lowest bit carries through a single run of ones
    det.be_gap  = wr_phase && (((bus.be + be_low) & bus.be) != '0);
    det.be_addr_mismatch = wr_phase && (bus.be != '0) &&
                           (bus.addr[lsb_width-1:0] != lowest_be(bus.be));
  end

  // Masked, one cycle after the offending bus cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      a_viol <= '0;
    end else begin
      a_viol <= det & enable.fields.a_flags;
    end
  end

endmodule

`default_nettype wire

//--- obi_r_phase_tracker.sv
// OBI response phase tracker
// Counts outstanding transactions, flags orphan rvalid and overflow
`timescale 1ns/1ps
`default_nettype none

module obi_r_phase_tracker
  import obi_mon_pkg::*;
#(
  parameter int unsigned max_outstanding = 4
) (
  input  wire           clk,
  input  wire           reset_n,
  obi_if.monitor        bus,
  input  viol_status_u  enable,
  output r_viol_flags_t r_viol,
  output logic          txn_done
);

  // Room for one beyond the limit
  localparam int unsigned cnt_width = $clog2(max_outstanding + 2);
  localparam logic [cnt_width-1:0] cnt_max = '1;

  logic [cnt_width-1:0] outstanding;
  logic                 a_acc;
  logic                 r_counted;
  r_viol_flags_t        det;

  always_comb begin
    a_acc     = bus.req && bus.gnt;
    // rvalid needs an earlier or same cycle address phase
    r_counted = bus.rvalid && ((outstanding != '0) || a_acc);

    det = '0;
    det.rvalid_orphan = bus.rvalid && !r_counted;
    // Accepting one more pushes the count past the limit
    det.outstanding_overflow = a_acc && !r_counted &&
                               (outstanding >= cnt_width'(max_outstanding));
  end

  // ------------------------------
  // Outstanding count
  // ------------------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      outstanding <= '0;
    end else if (a_acc && !r_counted) begin
      // Hold at the top rather than wrap
      if (outstanding != cnt_max) begin
        outstanding <= outstanding + 1'b1;
      end
    end else if (!a_acc && r_counted) begin
      outstanding <= outstanding - 1'b1;
    end
  end

  // Flags and completion share the one cycle latency
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      r_viol   <= '0;
      txn_done <= 1'b0;
    end else begin
      r_viol   <= det & enable.fields.r_flags;
      txn_done <= r_counted;
    end
  end

endmodule

`default_nettype wire

//--- obi_mon_regs.sv
// OBI monitor register block
// Enable mask, sticky status and counters behind a valid/ready port
`timescale 1ns/1ps
`default_nettype none

module obi_mon_regs
  import obi_mon_pkg::*;
(
  input  wire                  clk,
  input  wire                  reset_n,

  // Register request
  input  wire                  cfg_valid,
  output logic                 cfg_ready,
  input  wire                  cfg_write,
  input  wire  [1:0]           cfg_addr,
  input  wire  [cfg_width-1:0] cfg_wdata,

  // Register response
  output logic                 cfg_rsp_valid,
  input  wire                  cfg_rsp_ready,
  output logic [cfg_width-1:0] cfg_rdata,

  // Checker events
  input  viol_flags_t          a_viol,
  input  r_viol_flags_t        r_viol,
  input  wire                  txn_done,
  output viol_status_u         enable
);

  viol_status_u         ctrl_q;
  viol_status_u         status_q;
  logic [cfg_width-1:0] viol_count;
  logic [cfg_width-1:0] txn_count;

  logic                 accept;
  reg_addr_e            sel;
  viol_status_u         flags_in;
  logic [cfg_width-1:0] clr_mask;
  logic [cfg_width-1:0] rd_mux;

  // ------------------------------
  // Access decode
  // ------------------------------

  // Next request allowed once the pending response leaves
  assign cfg_ready = !cfg_rsp_valid || cfg_rsp_ready;
  assign accept    = cfg_valid && cfg_ready;
  assign sel       = reg_addr_e'(cfg_addr);
  assign enable    = ctrl_q;

  always_comb begin
    // Pack both phases into one status word
    flags_in                = '0;
    flags_in.fields.a_flags = a_viol;
    flags_in.fields.r_flags = r_viol;

    // Write one to clear
    clr_mask = '0;
    if (accept && cfg_write && (sel == reg_status)) begin
      clr_mask = cfg_wdata;
    end

    case (sel)
      reg_ctrl:       rd_mux = ctrl_q.raw;
      reg_status:     rd_mux = status_q.raw;
      reg_viol_count: rd_mux = viol_count;
      reg_txn_count:  rd_mux = txn_count;
      default:        rd_mux = '0;
    endcase
  end

  // ------------------------------
  // Register state
  // ------------------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl_q.raw   <= '1;
      status_q.raw <= '0;
    end else begin
      if (accept && cfg_write && (sel == reg_ctrl)) begin
        ctrl_q.raw <= cfg_wdata;
      end
      // New flag wins over a clear in the same cycle
      status_q.raw <= (status_q.raw & ~clr_mask) | flags_in.raw;
    end
  end

  // Saturating event counters
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      viol_count <= '0;
      txn_count  <= '0;
    end else begin
      if ((flags_in.raw != '0) && (viol_count != '1)) begin
        viol_count <= viol_count + 1'b1;
      end
      if (txn_done && (txn_count != '1)) begin
        txn_count <= txn_count + 1'b1;
      end
    end
  end

  // ------------------------------
  // Response
  // ------------------------------

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_rsp_valid <= 1'b0;
    end else if (accept) begin
      cfg_rsp_valid <= 1'b1;
    end else if (cfg_rsp_ready) begin
      cfg_rsp_valid <= 1'b0;
    end
  end

  // Read data sampled before the write lands; writes return zero
  always_ff @(posedge clk) begin
    if (accept) begin
      cfg_rdata <= cfg_write ? '0 : rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- obi_mon_top.sv
// OBI 1.1 protocol monitor top level
// Observes one link, checks both phases, exposes results over a register port
`timescale 1ns/1ps
`default_nettype none

module obi_mon_top
  import obi_mon_pkg::*;
#(
  parameter int unsigned addr_width      = obi_addr_width_default,
  parameter int unsigned data_width      = obi_data_width_default,
  parameter int unsigned max_outstanding = 4
) (
  input  wire                    clk,
  input  wire                    reset_n,

  // Monitored OBI link
  input  wire                    req,
  input  wire                    gnt,
  input  wire [addr_width-1:0]   addr,
  input  wire                    we,
  input  wire [data_width/8-1:0] be,
  input  wire [data_width-1:0]   wdata,
  input  wire                    rvalid,
  input  wire [data_width-1:0]   rdata,

  // Register port
  input  wire                    cfg_valid,
  output logic                   cfg_ready,
  input  wire                    cfg_write,
  input  wire [1:0]              cfg_addr,
  input  wire [cfg_width-1:0]    cfg_wdata,
  output logic                   cfg_rsp_valid,
  input  wire                    cfg_rsp_ready,
  output logic [cfg_width-1:0]   cfg_rdata
);

  obi_if #(
    .addr_width (addr_width),
    .data_width (data_width)
  ) bus_if ();

  viol_flags_t   a_viol;
  r_viol_flags_t r_viol;
  viol_status_u  enable;
  logic          txn_done;

  // Bus side of the bundle, driven from the pins
  assign bus_if.req    = req;
  assign bus_if.gnt    = gnt;
  assign bus_if.addr   = addr;
  assign bus_if.we     = we;
  assign bus_if.be     = be;
  assign bus_if.wdata  = wdata;
  assign bus_if.rvalid = rvalid;
  assign bus_if.rdata  = rdata;

  obi_a_phase_checker #(
    .addr_width (addr_width),
    .data_width (data_width)
  ) u_a_chk (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (bus_if.monitor),
    .enable  (enable),
    .a_viol  (a_viol)
  );

  obi_r_phase_tracker #(
    .max_outstanding (max_outstanding)
  ) u_r_trk (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus      (bus_if.monitor),
    .enable   (enable),
    .r_viol   (r_viol),
    .txn_done (txn_done)
  );

  // Mask source and result sink for both checkers
  obi_mon_regs u_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_valid     (cfg_valid),
    .cfg_ready     (cfg_ready),
    .cfg_write     (cfg_write),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_rsp_valid (cfg_rsp_valid),
    .cfg_rsp_ready (cfg_rsp_ready),
    .cfg_rdata     (cfg_rdata),
    .a_viol        (a_viol),
    .r_viol        (r_viol),
    .txn_done      (txn_done),
    .enable        (enable)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// Testbench clock and reset source
// Free running clock, reset held low for the first few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned period_ns    = 20,
  parameter int unsigned reset_cycles = 4
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_obi_mon.sv
// OBI monitor testbench
// Table of bus sequences with expected status and counters, checked over the register port
`timescale 1ns/1ps
`default_nettype none

module tb_obi_mon
  import obi_mon_pkg::*;
;

  // One bus cycle of a stimulus row
  // new_wd asks for fresh write data
  typedef struct packed {
    logic        req;
    logic        gnt;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic        new_wd;
    logic        rvalid;
  } bus_cyc_t;

  logic clk, reset_n;
  logic req, gnt, we, rvalid;
  logic [31:0] addr, wdata, rdata;
  logic [3:0] be;
  logic cfg_valid, cfg_ready, cfg_write, cfg_rsp_valid, cfg_rsp_ready;
  logic [1:0] cfg_addr;
  logic [15:0] cfg_wdata, cfg_rdata;

  // Stimulus table
  string       test_name [16];
  logic [15:0] test_mask [16];
  logic [15:0] exp_status [16];
  int          exp_viol [16];
  int          exp_txn [16];
  int          first_cyc [16];
  int          num_cyc [16];
  bus_cyc_t    cyc_tab [64];
  int          n_tests = 0;
  int          n_cycs = 0;
  logic        table_ready = 1'b0;

  // Running totals since the counters never clear
  int          exp_viol_total = 0;
  int          exp_txn_total = 0;
  int          error_count = 0;
  integer      seed;
  string       cur_name;

  tb_clk_gen #(.period_ns(20), .reset_cycles(4)) u_clk (.clk(clk), .reset_n(reset_n));

  obi_mon_top #(
    .addr_width (32),
    .data_width (32),
    .max_outstanding (4)
  ) uut (
    .clk (clk), .reset_n (reset_n),
    .req (req), .gnt (gnt), .addr (addr), .we (we), .be (be),
    .wdata (wdata), .rvalid (rvalid), .rdata (rdata),
    .cfg_valid (cfg_valid), .cfg_ready (cfg_ready), .cfg_write (cfg_write),
    .cfg_addr (cfg_addr), .cfg_wdata (cfg_wdata), .cfg_rsp_valid (cfg_rsp_valid),
    .cfg_rsp_ready (cfg_rsp_ready), .cfg_rdata (cfg_rdata)
  );

  // ------------------------------
  // Table building
  // ------------------------------

  task automatic add_test(input string name, input logic [15:0] mask,
                          input logic [15:0] status, input int viol, input int txn);
    test_name[n_tests]  = name;
    test_mask[n_tests]  = mask;
    exp_status[n_tests] = status;
    exp_viol[n_tests]   = viol;
    exp_txn[n_tests]    = txn;
    first_cyc[n_tests]  = n_cycs;
    num_cyc[n_tests]    = 0;
    n_tests++;
  endtask

  task automatic add_cyc(input logic rq, input logic gt, input logic [31:0] ad,
                         input logic wr, input logic [3:0] bytes, input logic nw,
                         input logic rv);
    bus_cyc_t c;
    c.req    = rq;
    c.gnt    = gt;
    c.addr   = ad;
    c.we     = wr;
    c.be     = bytes;
    c.new_wd = nw;
    c.rvalid = rv;
    cyc_tab[n_cycs] = c;
    n_cycs++;
    num_cyc[n_tests-1]++;
  endtask

  // Status bits are a-phase flags 6:0, rvalid_orphan 7 and outstanding_overflow 8
  task automatic build_table();
    add_test("legal_rw", 16'hffff, 16'h0000, 0, 2);
    add_cyc(1, 1, 32'h100, 1, 4'hf, 1, 0);
    add_cyc(1, 1, 32'h104, 0, 4'hf, 0, 1);
    add_cyc(0, 0, 32'h104, 0, 4'h0, 0, 1);
    add_test("legal_stall", 16'hffff, 16'h0000, 0, 1);
    add_cyc(1, 0, 32'h200, 1, 4'h3, 1, 0);
    add_cyc(1, 0, 32'h200, 1, 4'h3, 0, 0);
    add_cyc(1, 1, 32'h200, 1, 4'h3, 0, 0);
    add_cyc(0, 0, 32'h200, 0, 4'h0, 0, 1);
    add_test("addr_change", 16'hffff, 16'h0001, 1, 1);
    add_cyc(1, 0, 32'h300, 0, 4'hf, 0, 0);
    add_cyc(1, 1, 32'h304, 0, 4'hf, 0, 0);
    add_cyc(0, 0, 32'h304, 0, 4'h0, 0, 1);
    add_test("be_change", 16'hffff, 16'h0002, 1, 1);
    add_cyc(1, 0, 32'h400, 1, 4'hf, 1, 0);
    add_cyc(1, 1, 32'h400, 1, 4'h3, 0, 0);
    add_cyc(0, 0, 32'h400, 0, 4'h0, 0, 1);
    add_test("wdata_change", 16'hffff, 16'h0004, 1, 1);
    add_cyc(1, 0, 32'h500, 1, 4'hf, 1, 0);
    add_cyc(1, 1, 32'h500, 1, 4'hf, 1, 0);
    add_cyc(0, 0, 32'h500, 0, 4'h0, 0, 1);
    add_test("req_drop", 16'hffff, 16'h0008, 1, 0);
    add_cyc(1, 0, 32'h600, 0, 4'hf, 0, 0);
    add_cyc(0, 0, 32'h600, 0, 4'hf, 0, 0);
    add_test("be_zero", 16'hffff, 16'h0010, 1, 1);
    add_cyc(1, 1, 32'h700, 1, 4'h0, 1, 0);
    add_cyc(0, 0, 32'h700, 0, 4'h0, 0, 1);
    add_test("be_gap", 16'hffff, 16'h0020, 1, 1);
    add_cyc(1, 1, 32'h800, 1, 4'h5, 1, 0);
    add_cyc(0, 0, 32'h800, 0, 4'h0, 0, 1);
    add_test("be_addr", 16'hffff, 16'h0040, 1, 1);
    add_cyc(1, 1, 32'h901, 1, 4'hc, 1, 0);
    add_cyc(0, 0, 32'h901, 0, 4'h0, 0, 1);
    add_test("rvalid_orphan", 16'hffff, 16'h0080, 1, 0);
    add_cyc(0, 0, 32'h0, 0, 4'h0, 0, 1);
    // Five accepted reads against a limit of four before the drain
    add_test("overflow", 16'hffff, 16'h0100, 1, 5);
    repeat (5) add_cyc(1, 1, 32'ha00, 0, 4'hf, 0, 0);
    repeat (5) add_cyc(0, 0, 32'ha00, 0, 4'h0, 0, 1);
    add_test("masked", 16'hffef, 16'h0080, 1, 1);
    add_cyc(1, 1, 32'hc00, 1, 4'h0, 1, 0);
    add_cyc(0, 0, 32'hc00, 0, 4'h0, 0, 1);
    add_cyc(0, 0, 32'hc00, 0, 4'h0, 0, 1);
    // Two flags in one cycle count once
    add_test("multi_viol", 16'hffff, 16'h0070, 2, 2);
    add_cyc(1, 1, 32'hb01, 1, 4'h5, 1, 0);
    add_cyc(1, 1, 32'hb00, 1, 4'h0, 1, 1);
    add_cyc(0, 0, 32'hb00, 0, 4'h0, 0, 1);
  endtask

  // ------------------------------
  // Checks and drivers
  // ------------------------------

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Called and returns at a falling edge
  task automatic drive_cycle(input bus_cyc_t c);
    logic [31:0] next_wd;
    req    = c.req;
    gnt    = c.gnt;
    addr   = c.addr;
    we     = c.we;
    be     = c.be;
    rvalid = c.rvalid;
    if (c.new_wd) begin
      next_wd = $random(seed);
      // Fresh data must differ from the held value
      if (next_wd == wdata) next_wd = ~next_wd;
      wdata = next_wd;
    end
    rdata = c.rvalid ? $random(seed) : 32'h0;
    @(negedge clk);
  endtask

  task automatic drive_idle();
    req    = 1'b0;
    gnt    = 1'b0;
    we     = 1'b0;
    be     = 4'h0;
    rvalid = 1'b0;
    rdata  = 32'h0;
  endtask

  task automatic reg_access(input logic write, input logic [1:0] sel,
                            input logic [15:0] data_in, output logic [15:0] data_out);
    int waited;
    waited    = 0;
    cfg_valid = 1'b1;
    cfg_write = write;
    cfg_addr  = sel;
    cfg_wdata = data_in;
    while (!cfg_ready) begin
      @(negedge clk);
      waited++;
      if (waited > 10) begin
        $display("Register port never became ready in test %s", cur_name);
        $display("Test FAILED");
        $fatal(1);
      end
    end
    // Accepted at the rising edge in between
    @(negedge clk);
    cfg_valid = 1'b0;
    if (!cfg_rsp_valid) begin
      $display("No register response in the cycle after acceptance in test %s", cur_name);
      $display("Test FAILED");
      $fatal(1);
    end
    data_out = cfg_rdata;
    @(negedge clk);
  endtask

  task automatic run_test(input int t);
    logic [15:0] rd;
    cur_name = test_name[t];
    reg_access(1'b1, reg_ctrl, test_mask[t], rd);
    for (int i = 0; i < num_cyc[t]; i++) begin
      drive_cycle(cyc_tab[first_cyc[t] + i]);
    end
    drive_idle();
    // Flags land two edges after the last bus cycle
    repeat (2) @(negedge clk);
    exp_viol_total += exp_viol[t];
    exp_txn_total  += exp_txn[t];
    reg_access(1'b0, reg_status, 16'h0, rd);
    compare("status", exp_status[t], rd);
    reg_access(1'b0, reg_viol_count, 16'h0, rd);
    compare("viol_count", exp_viol_total, rd);
    reg_access(1'b0, reg_txn_count, 16'h0, rd);
    compare("txn_count", exp_txn_total, rd);
    reg_access(1'b0, reg_ctrl, 16'h0, rd);
    compare("ctrl", test_mask[t], rd);
    reg_access(1'b1, reg_status, 16'hffff, rd);
    compare("write response data", 16'h0, rd);
    reg_access(1'b0, reg_status, 16'h0, rd);
    compare("status after clear", 16'h0, rd);
  endtask

  // Response held while the consumer stalls
  task automatic check_backpressure();
    cur_name      = "backpressure";
    cfg_rsp_ready = 1'b0;
    cfg_valid     = 1'b1;
    cfg_write     = 1'b0;
    cfg_addr      = reg_txn_count;
    cfg_wdata     = 16'h0;
    compare("cfg_ready before accept", 1, cfg_ready);
    @(negedge clk);
    cfg_valid = 1'b0;
    repeat (3) begin
      compare("cfg_rsp_valid held", 1, cfg_rsp_valid);
      compare("cfg_ready held low", 0, cfg_ready);
      compare("held read data", exp_txn_total, cfg_rdata);
      @(negedge clk);
    end
    cfg_rsp_ready = 1'b1;
    // Ready follows the consumer within the same cycle
    #1;
    compare("cfg_ready on take", 1, cfg_ready);
    @(negedge clk);
    compare("cfg_rsp_valid after take", 0, cfg_rsp_valid);
  endtask

  // ------------------------------
  // Sequence and watchdog
  // ------------------------------

  initial begin
    seed = 32'h84b0;
    req = 1'b0;
    gnt = 1'b0;
    addr = 32'h0;
    we = 1'b0;
    be = 4'h0;
    wdata = 32'h0;
    rvalid = 1'b0;
    rdata = 32'h0;
    cfg_valid = 1'b0;
    cfg_write = 1'b0;
    cfg_addr = 2'd0;
    cfg_wdata = 16'h0;
    cfg_rsp_ready = 1'b1;
    build_table();
    table_ready = 1'b1;
    wait (reset_n === 1'b1);
    @(negedge clk);
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    check_backpressure();
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Forty cycles per row with room for reset and the back-pressure check
  initial begin
    wait (table_ready);
    repeat ((n_tests + 2) * 40) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("Test FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- all.f
obi_mon_pkg.sv
obi_if.sv
obi_a_phase_checker.sv
obi_r_phase_tracker.sv
obi_mon_regs.sv
obi_mon_top.sv
tb_clk_gen.sv
tb_obi_mon.sv

//--- Bender.yml
package:
  name: obi_mon

sources:
  # Monitor RTL in compile order
  - files:
      - obi_mon_pkg.sv
      - obi_if.sv
      - obi_a_phase_checker.sv
      - obi_r_phase_tracker.sv
      - obi_mon_regs.sv
      - obi_mon_top.sv
  # Simulation only
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_obi_mon.sv
